/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/lsu_if_pkg.sv
      - source/dcache_mem_pkg.sv
      - source/dcache_lane_align.sv
      - source/dcache_arrays.sv
      - source/dcache_ctrl.sv
      - source/dcache_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/dcache_checker.sv
      - verification/dcache_tb.sv

/* source/dcache_arrays.sv */
// Tag, metadata and line storage with hit compare and victim selection
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_arrays (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [`DCACHE_INDEX_W-1:0] rd_index_i,
  input  logic                       wr_en_i,
  input  logic [`DCACHE_INDEX_W-1:0] wr_index_i,
  input  dcache_mem_pkg::way_idx_t   wr_way_i,
  input  dcache_mem_pkg::tag_t       wr_tag_i,
  input  dcache_mem_pkg::meta_t      wr_meta_i,
  input  dcache_mem_pkg::line_t      wr_line_i,
  input  dcache_mem_pkg::tag_t       req_tag_i,
  output logic                       hit_o,
  output dcache_mem_pkg::way_idx_t   hit_way_o,
  output dcache_mem_pkg::line_t      hit_line_o,
  output dcache_mem_pkg::way_idx_t   victim_way_o,
  output logic                       victim_dirty_o,
  output dcache_mem_pkg::tag_t       victim_tag_o,
  output dcache_mem_pkg::line_t      victim_line_o
);

  dcache_mem_pkg::tag_t  tag_mem  [`DCACHE_SETS][`DCACHE_WAYS];
  dcache_mem_pkg::meta_t meta_mem [`DCACHE_SETS][`DCACHE_WAYS];
  dcache_mem_pkg::line_t line_mem [`DCACHE_SETS][`DCACHE_WAYS];

  // Registered read of one set
  dcache_mem_pkg::tag_t  rd_tag_q  [`DCACHE_WAYS];
  dcache_mem_pkg::meta_t rd_meta_q [`DCACHE_WAYS];
  dcache_mem_pkg::line_t rd_line_q [`DCACHE_WAYS];

  logic [3:0] lfsr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < `DCACHE_SETS; s++) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
          meta_mem[s][w] <= '0;
        end
      end
    end else if (wr_en_i) begin
      meta_mem[wr_index_i][wr_way_i] <= wr_meta_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tag_mem[wr_index_i][wr_way_i]  <= wr_tag_i;
      line_mem[wr_index_i][wr_way_i] <= wr_line_i;
    end
    rd_tag_q  <= tag_mem[rd_index_i];
    rd_meta_q <= meta_mem[rd_index_i];
    rd_line_q <= line_mem[rd_index_i];
  end

  // Free-running x^4 + x^3 + 1 sequence for random replacement
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 4'b0001;
    end else begin
      lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
    end
  end

  // --------------------------------------------------
  // Hit compare and victim choice
  // --------------------------------------------------
  always_comb begin
    hit_o        = 1'b0;
    hit_way_o    = '0;
    victim_way_o = lfsr_q[$bits(dcache_mem_pkg::way_idx_t)-1:0];
    // Descending scan so the lowest invalid way wins
    for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
      if (rd_meta_q[w].valid && (rd_tag_q[w] == req_tag_i)) begin
        hit_o     = 1'b1;
        hit_way_o = dcache_mem_pkg::way_idx_t'(w);
      end
      if (!rd_meta_q[w].valid) begin
        victim_way_o = dcache_mem_pkg::way_idx_t'(w);
      end
    end
  end

  assign hit_line_o     = rd_line_q[hit_way_o];
  assign victim_tag_o   = rd_tag_q[victim_way_o];
  assign victim_line_o  = rd_line_q[victim_way_o];
  assign victim_dirty_o = rd_meta_q[victim_way_o].valid && rd_meta_q[victim_way_o].dirty;

endmodule

/* source/dcache_config.svh */
// Fixed geometry of the two-way write-back data cache
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Processor data and physical address widths
`define DCACHE_XLEN 32
`define DCACHE_PLEN 32

// Line and set organisation
`define DCACHE_LINE_BITS 128
`define DCACHE_WAYS 2
`define DCACHE_SETS 8

// Address split: tag | index | offset
`define DCACHE_OFFSET_W 4
`define DCACHE_INDEX_W 3
`define DCACHE_TAG_W (`DCACHE_PLEN - `DCACHE_INDEX_W - `DCACHE_OFFSET_W)

`endif

/* source/dcache_ctrl.sv */
// Request arbitration and miss/writeback sequencing of the data cache
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          ld_req_valid_i,
  input  lsu_if_pkg::ld_req_t           ld_req_i,
  output logic                          ld_req_ready_o,
  input  logic                          st_req_valid_i,
  input  lsu_if_pkg::st_req_t           st_req_i,
  output logic                          st_req_ready_o,
  output logic                          ld_rsp_valid_o,
  output lsu_if_pkg::ld_rsp_t           ld_rsp_o,
  output logic                          miss_req_valid_o,
  output dcache_mem_pkg::mem_req_t      miss_req_o,
  input  logic                          miss_req_ready_i,
  input  logic                          refill_valid_i,
  input  dcache_mem_pkg::line_t         refill_line_i,
  output logic                          wb_req_valid_o,
  output dcache_mem_pkg::wb_req_t       wb_req_o,
  input  logic                          wb_req_ready_i,
  output logic [`DCACHE_INDEX_W-1:0]    rd_index_o,
  output logic                          wr_en_o,
  output logic [`DCACHE_INDEX_W-1:0]    wr_index_o,
  output dcache_mem_pkg::way_idx_t      wr_way_o,
  output dcache_mem_pkg::tag_t          wr_tag_o,
  output dcache_mem_pkg::meta_t         wr_meta_o,
  output dcache_mem_pkg::line_t         wr_line_o,
  input  logic                          hit_i,
  input  dcache_mem_pkg::way_idx_t      hit_way_i,
  input  dcache_mem_pkg::way_idx_t      victim_way_i,
  input  logic                          victim_dirty_i,
  input  dcache_mem_pkg::tag_t          victim_tag_i,
  input  dcache_mem_pkg::line_t         victim_line_i,
  input  dcache_mem_pkg::line_t         hit_line_i,
  output lsu_if_pkg::lsu_op_e           align_op_o,
  output logic [`DCACHE_OFFSET_W-1:0]   align_offset_o,
  output logic [`DCACHE_XLEN-1:0]       align_wdata_o,
  output dcache_mem_pkg::line_t         align_line_o,
  input  logic [`DCACHE_XLEN-1:0]       load_data_i,
  input  dcache_mem_pkg::line_t         merged_line_i
);

  dcache_mem_pkg::dcache_state_e state_q, state_d;

  logic                     accept_ld;
  logic                     accept;
  logic                     refill_done;
  logic [`DCACHE_PLEN-1:0]  sel_addr;
  logic                     req_is_store_q;
  logic [`DCACHE_PLEN-1:0]  req_addr_q;
  lsu_if_pkg::lsu_op_e      req_op_q;
  logic [`DCACHE_XLEN-1:0]  req_wdata_q;
  dcache_mem_pkg::way_idx_t victim_way_q;
  dcache_mem_pkg::wb_req_t  wb_req_q;
  logic [`DCACHE_XLEN-1:0]  rsp_data_q;

  // --------------------------------------------------
  // Arbitration, load has priority over store
  // --------------------------------------------------
  assign ld_req_ready_o = (state_q == dcache_mem_pkg::IDLE);
  assign st_req_ready_o = ld_req_ready_o && !ld_req_valid_i;
  assign accept_ld      = ld_req_valid_i && ld_req_ready_o;
  assign accept         = accept_ld || (st_req_valid_i && st_req_ready_o);
  assign sel_addr       = accept_ld ? ld_req_i.addr : st_req_i.addr;
  assign refill_done    = (state_q == dcache_mem_pkg::WAIT_REFILL) && refill_valid_i;

  // Read the incoming set in IDLE, otherwise keep re-reading the request set
  assign rd_index_o = ld_req_ready_o ? sel_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W]
                                     : req_addr_q[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= dcache_mem_pkg::IDLE;
      req_is_store_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        req_is_store_q <= !accept_ld;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_addr_q  <= sel_addr;
      req_op_q    <= accept_ld ? ld_req_i.op : st_req_i.op;
      req_wdata_q <= st_req_i.data;
    end
    // Victim context for a miss
    if (state_q == dcache_mem_pkg::LOOKUP && !hit_i) begin
      victim_way_q  <= victim_way_i;
      wb_req_q.addr <= {victim_tag_i, req_addr_q[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W],
                        {`DCACHE_OFFSET_W{1'b0}}};
      wb_req_q.line <= victim_line_i;
    end
    if ((state_q == dcache_mem_pkg::LOOKUP && hit_i) || refill_done) begin
      rsp_data_q <= load_data_i;
    end
  end

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      dcache_mem_pkg::IDLE: begin
        if (accept) begin
          state_d = dcache_mem_pkg::LOOKUP;
        end
      end
      dcache_mem_pkg::LOOKUP: begin
        if (hit_i) begin
          state_d = req_is_store_q ? dcache_mem_pkg::STORE_WRITE : dcache_mem_pkg::RESP;
        end else if (victim_dirty_i) begin
          state_d = dcache_mem_pkg::WB_REQ;
        end else begin
          state_d = dcache_mem_pkg::MISS_REQ;
        end
      end
      dcache_mem_pkg::STORE_WRITE: state_d = dcache_mem_pkg::IDLE;
      dcache_mem_pkg::WB_REQ: begin
        if (wb_req_ready_i) begin
          state_d = dcache_mem_pkg::MISS_REQ;
        end
      end
      dcache_mem_pkg::MISS_REQ: begin
        if (miss_req_ready_i) begin
          state_d = dcache_mem_pkg::WAIT_REFILL;
        end
      end
      dcache_mem_pkg::WAIT_REFILL: begin
        if (refill_valid_i) begin
          state_d = req_is_store_q ? dcache_mem_pkg::IDLE : dcache_mem_pkg::RESP;
        end
      end
      default: state_d = dcache_mem_pkg::IDLE;
    endcase
  end

  // --------------------------------------------------
  // Outputs, array writes and aligner feed
  // --------------------------------------------------
  assign wb_req_valid_o   = (state_q == dcache_mem_pkg::WB_REQ);
  assign wb_req_o         = wb_req_q;
  assign miss_req_valid_o = (state_q == dcache_mem_pkg::MISS_REQ);
  assign miss_req_o.addr  = {req_addr_q[`DCACHE_PLEN-1:`DCACHE_OFFSET_W],
                             {`DCACHE_OFFSET_W{1'b0}}};
  assign ld_rsp_valid_o   = (state_q == dcache_mem_pkg::RESP);
  assign ld_rsp_o.data    = rsp_data_q;

  // In STORE_WRITE the arrays still hold the re-read request set, so the
  // hit way and merged line are those seen in LOOKUP
  assign wr_en_o         = (state_q == dcache_mem_pkg::STORE_WRITE) || refill_done;
  assign wr_index_o      = req_addr_q[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
  assign wr_way_o        = (state_q == dcache_mem_pkg::STORE_WRITE) ? hit_way_i : victim_way_q;
  assign wr_tag_o        = req_addr_q[`DCACHE_PLEN-1 -: `DCACHE_TAG_W];
  assign wr_meta_o.dirty = req_is_store_q;
  assign wr_meta_o.valid = 1'b1;
  assign wr_line_o       = merged_line_i;

  assign align_op_o     = req_op_q;
  assign align_offset_o = req_addr_q[`DCACHE_OFFSET_W-1:0];
  assign align_wdata_o  = req_wdata_q;
  assign align_line_o   = (state_q == dcache_mem_pkg::WAIT_REFILL) ? refill_line_i : hit_line_i;

endmodule

/* source/dcache_lane_align.sv */
// Load data extraction from a cache line and store merge into it
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_lane_align (
  input  lsu_if_pkg::lsu_op_e         op_i,
  input  logic [`DCACHE_OFFSET_W-1:0] offset_i,
  input  logic [`DCACHE_XLEN-1:0]     wdata_i,
  input  dcache_mem_pkg::line_t       line_i,
  output logic [`DCACHE_XLEN-1:0]     load_data_o,
  output dcache_mem_pkg::line_t       merged_line_o
);

  // Bit positions of the addressed byte and of its enclosing word
  logic [`DCACHE_OFFSET_W+2:0] byte_pos;
  logic [`DCACHE_OFFSET_W+2:0] word_pos;
  logic [7:0]                  byte_val;
  logic [`DCACHE_XLEN-1:0]     word_val;

  assign byte_pos = {offset_i, 3'b000};
  assign word_pos = {offset_i[`DCACHE_OFFSET_W-1:2], 5'b00000};
  assign byte_val = line_i[byte_pos +: 8];
  assign word_val = line_i[word_pos +: `DCACHE_XLEN];

  // --------------------------------------------------
  // Load lane
  // --------------------------------------------------
  always_comb begin
    unique case (op_i)
      lsu_if_pkg::LSU_LB:  load_data_o = {{(`DCACHE_XLEN-8){byte_val[7]}}, byte_val};
      lsu_if_pkg::LSU_LBU: load_data_o = {{(`DCACHE_XLEN-8){1'b0}}, byte_val};
      lsu_if_pkg::LSU_LW:  load_data_o = word_val;
      default:             load_data_o = '0;
    endcase
  end

  // --------------------------------------------------
  // Store merge, loads pass the line through unchanged
  // --------------------------------------------------
  always_comb begin
    merged_line_o = line_i;
    unique case (op_i)
      lsu_if_pkg::LSU_SB: merged_line_o[byte_pos +: 8] = wdata_i[7:0];
      lsu_if_pkg::LSU_SW: merged_line_o[word_pos +: `DCACHE_XLEN] = wdata_i;
      default: ;
    endcase
  end

endmodule

/* source/dcache_mem_pkg.sv */
// Storage, metadata and lower-memory types of the data cache
`include "dcache_config.svh"

package dcache_mem_pkg;

  typedef logic [`DCACHE_TAG_W-1:0]         tag_t;
  typedef logic [`DCACHE_LINE_BITS-1:0]     line_t;
  typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_idx_t;

  typedef struct packed {
    logic dirty;
    logic valid;
  } meta_t;

  // Line-aligned miss address
  typedef struct packed {
    logic [`DCACHE_PLEN-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [`DCACHE_PLEN-1:0] addr;
    line_t                   line;
  } wb_req_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    STORE_WRITE,
    WB_REQ,
    MISS_REQ,
    WAIT_REFILL,
    RESP
  } dcache_state_e;

endpackage

/* source/dcache_top.sv */
// Blocking two-way write-back data cache with load and committed-store ports
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     ld_req_valid_i,
  input  lsu_if_pkg::ld_req_t      ld_req_i,
  output logic                     ld_req_ready_o,
  input  logic                     st_req_valid_i,
  input  lsu_if_pkg::st_req_t      st_req_i,
  output logic                     st_req_ready_o,
  output logic                     ld_rsp_valid_o,
  output lsu_if_pkg::ld_rsp_t      ld_rsp_o,
  output logic                     miss_req_valid_o,
  output dcache_mem_pkg::mem_req_t miss_req_o,
  input  logic                     miss_req_ready_i,
  input  logic                     refill_valid_i,
  input  dcache_mem_pkg::line_t    refill_line_i,
  output logic                     wb_req_valid_o,
  output dcache_mem_pkg::wb_req_t  wb_req_o,
  input  logic                     wb_req_ready_i
);

  logic [`DCACHE_INDEX_W-1:0]  rd_index;
  logic                        wr_en;
  logic [`DCACHE_INDEX_W-1:0]  wr_index;
  dcache_mem_pkg::way_idx_t    wr_way;
  dcache_mem_pkg::tag_t        wr_tag;
  dcache_mem_pkg::meta_t       wr_meta;
  dcache_mem_pkg::line_t       wr_line;
  logic                        hit;
  logic                        victim_dirty;
  dcache_mem_pkg::way_idx_t    hit_way;
  dcache_mem_pkg::way_idx_t    victim_way;
  dcache_mem_pkg::tag_t        victim_tag;
  dcache_mem_pkg::line_t       victim_line;
  dcache_mem_pkg::line_t       hit_line;
  lsu_if_pkg::lsu_op_e         align_op;
  logic [`DCACHE_OFFSET_W-1:0] align_offset;
  logic [`DCACHE_XLEN-1:0]     align_wdata;
  logic [`DCACHE_XLEN-1:0]     load_data;
  dcache_mem_pkg::line_t       align_line;
  dcache_mem_pkg::line_t       merged_line;

  dcache_ctrl i_dcache_ctrl (
    .clk_i, .rst_ni,
    .ld_req_valid_i, .ld_req_i, .ld_req_ready_o,
    .st_req_valid_i, .st_req_i, .st_req_ready_o,
    .ld_rsp_valid_o, .ld_rsp_o,
    .miss_req_valid_o, .miss_req_o, .miss_req_ready_i,
    .refill_valid_i, .refill_line_i,
    .wb_req_valid_o, .wb_req_o, .wb_req_ready_i,
    .rd_index_o     (rd_index),
    .wr_en_o        (wr_en),
    .wr_index_o     (wr_index),
    .wr_way_o       (wr_way),
    .wr_tag_o       (wr_tag),
    .wr_meta_o      (wr_meta),
    .wr_line_o      (wr_line),
    .hit_i          (hit),
    .hit_way_i      (hit_way),
    .victim_way_i   (victim_way),
    .victim_dirty_i (victim_dirty),
    .victim_tag_i   (victim_tag),
    .victim_line_i  (victim_line),
    .hit_line_i     (hit_line),
    .align_op_o     (align_op),
    .align_offset_o (align_offset),
    .align_wdata_o  (align_wdata),
    .align_line_o   (align_line),
    .load_data_i    (load_data),
    .merged_line_i  (merged_line)
  );

  // The write tag is always the request tag, so it also drives the compare
  dcache_arrays i_dcache_arrays (
    .clk_i, .rst_ni,
    .rd_index_i     (rd_index),
    .wr_en_i        (wr_en),
    .wr_index_i     (wr_index),
    .wr_way_i       (wr_way),
    .wr_tag_i       (wr_tag),
    .wr_meta_i      (wr_meta),
    .wr_line_i      (wr_line),
    .req_tag_i      (wr_tag),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .hit_line_o     (hit_line),
    .victim_way_o   (victim_way),
    .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag),
    .victim_line_o  (victim_line)
  );

  dcache_lane_align i_dcache_lane_align (
    .op_i          (align_op),
    .offset_i      (align_offset),
    .wdata_i       (align_wdata),
    .line_i        (align_line),
    .load_data_o   (load_data),
    .merged_line_o (merged_line)
  );

endmodule

/* source/lsu_if_pkg.sv */
// Processor-side load/store operation codes and request/response types
`include "dcache_config.svh"

package lsu_if_pkg;

  typedef enum logic [2:0] {
    LSU_LB,
    LSU_LBU,
    LSU_LW,
    LSU_SB,
    LSU_SW
  } lsu_op_e;

  typedef struct packed {
    logic [`DCACHE_PLEN-1:0] addr;
    lsu_op_e                 op;
  } ld_req_t;

  // Committed store from the store buffer
  typedef struct packed {
    logic [`DCACHE_PLEN-1:0] addr;
    logic [`DCACHE_XLEN-1:0] data;
    lsu_op_e                 op;
  } st_req_t;

  typedef struct packed {
    logic [`DCACHE_XLEN-1:0] data;
  } ld_rsp_t;

endpackage

/* verification/dcache_checker.sv */
// Handshake, stall and alignment assertions for the data cache
`timescale 1ns/1ps

module dcache_checker (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     ld_req_valid_i,
  input lsu_if_pkg::ld_req_t      ld_req_i,
  input logic                     ld_req_ready_o,
  input logic                     st_req_valid_i,
  input lsu_if_pkg::st_req_t      st_req_i,
  input logic                     st_req_ready_o,
  input logic                     ld_rsp_valid_o,
  input logic                     miss_req_valid_o,
  input dcache_mem_pkg::mem_req_t miss_req_o,
  input logic                     miss_req_ready_i,
  input logic                     refill_valid_i,
  input logic                     wb_req_valid_o,
  input dcache_mem_pkg::wb_req_t  wb_req_o,
  input logic                     wb_req_ready_i
);

  // Set from the miss transfer until the refill arrives
  logic miss_pending_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      miss_pending_q <= 1'b0;
    end else if (miss_req_valid_o && miss_req_ready_i) begin
      miss_pending_q <= 1'b1;
    end else if (refill_valid_i) begin
      miss_pending_q <= 1'b0;
    end
  end

  // --------------------------------------------------
  // Protocol properties
  // --------------------------------------------------
  rsp_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ld_rsp_valid_o |=> !ld_rsp_valid_o)
    else $error("load response valid lasted more than one cycle");

  miss_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    miss_req_valid_o && !miss_req_ready_i |=> miss_req_valid_o && $stable(miss_req_o))
    else $error("miss request dropped or changed before its ready");

  wb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_req_valid_o && !wb_req_ready_i |=> wb_req_valid_o && $stable(wb_req_o))
    else $error("writeback request dropped or changed before its ready");

  stall_on_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (miss_req_valid_o || wb_req_valid_o || miss_pending_q) |->
      !ld_req_ready_o && !st_req_ready_o)
    else $error("request port ready while a miss or writeback is outstanding");

  ld_word_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ld_req_valid_i && ld_req_ready_o && ld_req_i.op == lsu_if_pkg::LSU_LW |->
      ld_req_i.addr[1:0] == 2'b00)
    else $error("misaligned word load accepted");

  st_word_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    st_req_valid_i && st_req_ready_o && st_req_i.op == lsu_if_pkg::LSU_SW |->
      st_req_i.addr[1:0] == 2'b00)
    else $error("misaligned word store accepted");

endmodule

bind dcache_top dcache_checker i_dcache_checker (.*);

/* verification/dcache_tb.sv */
// Testbench for the two-way data cache with a byte-array memory model
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_tb;

  localparam int MEM_BYTES   = 4096;
  localparam int TIMEOUT_CYC = 100;
  localparam int EV_LD_ACC   = 0;
  localparam int EV_ST_ACC   = 1;
  localparam int EV_RSP      = 2;

  typedef struct packed {
    lsu_if_pkg::lsu_op_e     op;
    logic [`DCACHE_PLEN-1:0] addr;
    logic [`DCACHE_XLEN-1:0] wdata;
    logic [`DCACHE_XLEN-1:0] expected;
    logic                    hit_timing;  // hit latency must be 2 cycles
    logic                    with_next;   // presented together with the next store
  } stim_t;

  logic                     clk_i = 1'b0;
  logic                     rst_ni = 1'b0;
  logic                     ld_req_valid_i;
  lsu_if_pkg::ld_req_t      ld_req_i;
  logic                     ld_req_ready_o;
  logic                     st_req_valid_i;
  lsu_if_pkg::st_req_t      st_req_i;
  logic                     st_req_ready_o;
  logic                     ld_rsp_valid_o;
  lsu_if_pkg::ld_rsp_t      ld_rsp_o;
  logic                     miss_req_valid_o;
  dcache_mem_pkg::mem_req_t miss_req_o;
  logic                     miss_req_ready_i;
  logic                     refill_valid_i;
  dcache_mem_pkg::line_t    refill_line_i;
  logic                     wb_req_valid_o;
  dcache_mem_pkg::wb_req_t  wb_req_o;
  logic                     wb_req_ready_i;

  logic [7:0]  mem       [MEM_BYTES];
  logic [7:0]  model_mem [MEM_BYTES];
  stim_t       stim_q    [$];
  integer      seed = 19;
  int          miss_cnt;
  int          wb_cnt;
  logic [31:0] refill_addr;
  int          cycle_cnt = 0;
  int          ld_acc_cnt = 0;
  int          st_acc_cnt = 0;
  int          rsp_cnt = 0;
  int          ld_acc_cycle;
  int          rsp_cycle;
  logic [31:0] rsp_data;
  logic        st_ready_at_ld_acc;
  int          checks = 0;
  int          errors = 0;

  dcache_top i_dcache_top (.*);

  initial begin
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [7:0] pattern_byte(input int unsigned a);
    logic [31:0] v;
    v = a * 7 + 3;
    return v[7:0];
  endfunction

  function automatic int rand_delay();
    return 1 + ({$random(seed)} % 4);
  endfunction

  function automatic dcache_mem_pkg::line_t read_line(input logic [31:0] addr);
    dcache_mem_pkg::line_t line;
    for (int b = 0; b < 16; b++) begin
      line[b*8 +: 8] = mem[(addr + b) % MEM_BYTES];
    end
    return line;
  endfunction

  // Expected load value from the pattern rule, stores update the shadow copy
  function automatic logic [31:0] model_access(input lsu_if_pkg::lsu_op_e op,
                                               input logic [31:0] addr,
                                               input logic [31:0] wdata);
    logic [31:0] result;
    logic [7:0]  b;
    result = '0;
    b = model_mem[addr];
    case (op)
      lsu_if_pkg::LSU_LB:  result = {{24{b[7]}}, b};
      lsu_if_pkg::LSU_LBU: result = {24'h0, b};
      lsu_if_pkg::LSU_LW: begin
        result = {model_mem[addr+3], model_mem[addr+2], model_mem[addr+1], b};
      end
      lsu_if_pkg::LSU_SB:  model_mem[addr] = wdata[7:0];
      default: begin
        for (int k = 0; k < 4; k++) begin
          model_mem[addr+k] = wdata[k*8 +: 8];
        end
      end
    endcase
    return result;
  endfunction

  function automatic int event_count(input int kind);
    int n;
    case (kind)
      EV_LD_ACC: n = ld_acc_cnt;
      EV_ST_ACC: n = st_acc_cnt;
      default:   n = rsp_cnt;
    endcase
    return n;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic wait_count(input int kind, input int base, input string what);
    int waited;
    waited = 0;
    while (event_count(kind) == base && waited < TIMEOUT_CYC) begin
      @(negedge clk_i);
      waited++;
    end
    if (event_count(kind) == base) begin
      $display("Timeout after %0d cycles waiting for the %s", waited, what);
      $display("*** TEST FAILED ***");
      $finish;
    end
  endtask

  task automatic add_entry(input lsu_if_pkg::lsu_op_e op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic hit_timing,
                           input logic with_next);
    stim_t s;
    s.op         = op;
    s.addr       = addr;
    s.wdata      = wdata;
    s.hit_timing = hit_timing;
    s.with_next  = with_next;
    s.expected   = model_access(op, addr, wdata);
    stim_q.push_back(s);
  endtask

  // --------------------------------------------------
  // Memory model, answers on the falling edge
  // --------------------------------------------------
  always @(negedge clk_i) begin : miss_model
    refill_valid_i = 1'b0;
    if (!rst_ni) begin
      miss_req_ready_i = 1'b0;
      miss_cnt = -1;
    end else if (miss_req_ready_i) begin
      // Request taken on the last rising edge
      miss_req_ready_i = 1'b0;
      refill_valid_i = 1'b1;
      refill_line_i = read_line(refill_addr);
    end else if (miss_req_valid_o) begin
      if (miss_cnt < 0) begin
        miss_cnt = rand_delay();
      end
      miss_cnt--;
      if (miss_cnt == 0) begin
        miss_req_ready_i = 1'b1;
        refill_addr = miss_req_o.addr;
        miss_cnt = -1;
      end
    end
  end

  always @(negedge clk_i) begin : wb_model
    if (!rst_ni || wb_req_ready_i) begin
      wb_req_ready_i = 1'b0;
      wb_cnt = -1;
    end else if (wb_req_valid_o) begin
      if (wb_cnt < 0) begin
        wb_cnt = rand_delay();
      end
      wb_cnt--;
      if (wb_cnt == 0) begin
        wb_req_ready_i = 1'b1;
        wb_cnt = -1;
        for (int b = 0; b < 16; b++) begin
          mem[(wb_req_o.addr + b) % MEM_BYTES] = wb_req_o.line[b*8 +: 8];
        end
      end
    end
  end

  always @(posedge clk_i) begin : event_monitor
    cycle_cnt++;
    if (ld_req_valid_i && ld_req_ready_o) begin
      ld_acc_cnt++;
      ld_acc_cycle = cycle_cnt;
      st_ready_at_ld_acc = st_req_ready_o;
    end
    if (st_req_valid_i && st_req_ready_o) begin
      st_acc_cnt++;
    end
    if (ld_rsp_valid_o) begin
      rsp_cnt++;
      rsp_cycle = cycle_cnt;
      rsp_data = ld_rsp_o.data;
    end
  end

  task automatic finish_load(input stim_t s, input int base_rsp);
    wait_count(EV_RSP, base_rsp, "load response");
    check_value($sformatf("load data at 0x%08h", s.addr), rsp_data, s.expected);
    if (s.hit_timing) begin
      check_value("load hit latency", rsp_cycle - ld_acc_cycle, 2);
    end
  endtask

  task automatic run_single(input stim_t s);
    int base_acc;
    int base_rsp;
    @(negedge clk_i);
    base_rsp = rsp_cnt;
    if (s.op == lsu_if_pkg::LSU_SB || s.op == lsu_if_pkg::LSU_SW) begin
      base_acc = st_acc_cnt;
      st_req_valid_i = 1'b1;
      st_req_i.addr = s.addr;
      st_req_i.data = s.wdata;
      st_req_i.op = s.op;
      wait_count(EV_ST_ACC, base_acc, "store accept");
      st_req_valid_i = 1'b0;
    end else begin
      base_acc = ld_acc_cnt;
      ld_req_valid_i = 1'b1;
      ld_req_i.addr = s.addr;
      ld_req_i.op = s.op;
      wait_count(EV_LD_ACC, base_acc, "load accept");
      ld_req_valid_i = 1'b0;
      finish_load(s, base_rsp);
    end
  endtask

  // Load and store raised together, the load must win
  task automatic run_dual(input stim_t ld, input stim_t st);
    int base_ld;
    int base_st;
    int base_rsp;
    @(negedge clk_i);
    base_ld = ld_acc_cnt;
    base_st = st_acc_cnt;
    base_rsp = rsp_cnt;
    ld_req_valid_i = 1'b1;
    ld_req_i.addr = ld.addr;
    ld_req_i.op = ld.op;
    st_req_valid_i = 1'b1;
    st_req_i.addr = st.addr;
    st_req_i.data = st.wdata;
    st_req_i.op = st.op;
    wait_count(EV_LD_ACC, base_ld, "load accept");
    ld_req_valid_i = 1'b0;
    check_value("store ready at load accept", st_ready_at_ld_acc, 1'b0);
    check_value("stores accepted with the load", st_acc_cnt - base_st, 0);
    finish_load(ld, base_rsp);
    wait_count(EV_ST_ACC, base_st, "store accept");
    st_req_valid_i = 1'b0;
  endtask

  initial begin
    int i;
    ld_req_valid_i = 1'b0;
    ld_req_i = '0;
    st_req_valid_i = 1'b0;
    st_req_i = '0;
    miss_req_ready_i = 1'b0;
    refill_valid_i = 1'b0;
    refill_line_i = '0;
    wb_req_ready_i = 1'b0;
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem[a] = pattern_byte(a);
      model_mem[a] = pattern_byte(a);
    end

    // Load miss, then a hit in the same line
    add_entry(lsu_if_pkg::LSU_LW, 32'h000, '0, 1'b0, 1'b0);
    add_entry(lsu_if_pkg::LSU_LW, 32'h008, '0, 1'b1, 1'b0);
    // Byte 0x20 holds 0xe3
    add_entry(lsu_if_pkg::LSU_LB, 32'h020, '0, 1'b0, 1'b0);
    add_entry(lsu_if_pkg::LSU_LBU, 32'h020, '0, 1'b1, 1'b0);
    // Store hits merged into pattern words
    add_entry(lsu_if_pkg::LSU_SW, 32'h024, 32'h1234_5678, 1'b0, 1'b0);
    add_entry(lsu_if_pkg::LSU_SB, 32'h026, 32'h0000_00a5, 1'b0, 1'b0);
    add_entry(lsu_if_pkg::LSU_SB, 32'h021, 32'h0000_005a, 1'b0, 1'b0);
    add_entry(lsu_if_pkg::LSU_LW, 32'h024, '0, 1'b1, 1'b0);
    add_entry(lsu_if_pkg::LSU_LW, 32'h020, '0, 1'b1, 1'b0);
    // Write-allocate on a store miss
    add_entry(lsu_if_pkg::LSU_SW, 32'h040, 32'hcafe_f00d, 1'b0, 1'b0);
    add_entry(lsu_if_pkg::LSU_LW, 32'h040, '0, 1'b1, 1'b0);
    // Three lines of set 6 force a dirty writeback
    add_entry(lsu_if_pkg::LSU_SW, 32'h060, 32'h1111_1111, 1'b0, 1'b0);
    add_entry(lsu_if_pkg::LSU_SW, 32'h0e4, 32'h2222_2222, 1'b0, 1'b0);
    add_entry(lsu_if_pkg::LSU_LW, 32'h160, '0, 1'b0, 1'b0);
    add_entry(lsu_if_pkg::LSU_LW, 32'h060, '0, 1'b0, 1'b0);
    add_entry(lsu_if_pkg::LSU_LW, 32'h0e4, '0, 1'b0, 1'b0);
    add_entry(lsu_if_pkg::LSU_LW, 32'h160, '0, 1'b0, 1'b0);
    // Same-cycle load and store
    add_entry(lsu_if_pkg::LSU_LW, 32'h100, '0, 1'b0, 1'b1);
    add_entry(lsu_if_pkg::LSU_SW, 32'h104, 32'h0bad_beef, 1'b0, 1'b0);
    add_entry(lsu_if_pkg::LSU_LW, 32'h104, '0, 1'b1, 1'b0);

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("ready outputs after reset", {ld_req_ready_o, st_req_ready_o}, 2'b11);
    check_value("valid outputs after reset",
                {ld_rsp_valid_o, miss_req_valid_o, wb_req_valid_o}, 3'b000);

    i = 0;
    while (i < stim_q.size()) begin
      if (stim_q[i].with_next && i + 1 < stim_q.size()) begin
        run_dual(stim_q[i], stim_q[i+1]);
        i += 2;
      end else begin
        run_single(stim_q[i]);
        i += 1;
      end
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+source
source/lsu_if_pkg.sv
source/dcache_mem_pkg.sv
source/dcache_lane_align.sv
source/dcache_arrays.sv
source/dcache_ctrl.sv
source/dcache_top.sv
verification/dcache_checker.sv
verification/dcache_tb.sv
